// ==== common/dist_pkg.sv ====
package dist_pkg;

	// operand and port geometry
	localparam int DATA_WIDTH = 32;
	localparam int NUM_PORTS = 8;

	// register levels per tree, fan-out and mux alike
	localparam int TREE_DEPTH = 3;

	// one fan-out tree followed by one mux tree
	localparam int XBAR_LATENCY = 2 * TREE_DEPTH;

	// one select bit per input/lane pair, bit i*8+j routes input i to lane j
	localparam int CMD_WIDTH = NUM_PORTS * NUM_PORTS;

	// command table
	localparam int MAX_ROUNDS = 4;
	localparam int ROUND_BITS = 2;

	// round index and drain timer share one counter
	localparam int COUNT_BITS = 3;

	typedef enum logic [1:0]
	{
		ST_IDLE,  // waiting for start
		ST_ISSUE, // one round per enabled cycle
		ST_DRAIN, // pipeline emptying
		ST_DONE   // single completion cycle
	} seq_state_e;

endpackage

// ==== design/crossbar/fanout_tree.sv ====
`timescale 1ns/1ps

module fanout_tree
(
	input  logic                                          CLK,
	input  logic                                          i_rst,
	input  logic                                          i_en,
	input  logic                                          i_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]               i_data,
	input  logic [dist_pkg::NUM_PORTS-1:0]                i_cmd,
	output logic [dist_pkg::NUM_PORTS-1:0]                o_valid,
	output logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] o_data,
	output logic [dist_pkg::NUM_PORTS-1:0]                o_cmd
);

	genvar lvl;

	// level lvl doubles the copies; leaf n ends up owning command bit n
	generate
		for (lvl = 0; lvl < dist_pkg::TREE_DEPTH; lvl++)
		begin : g_level
			localparam int NODES = 2 << lvl;
			localparam int DW = dist_pkg::DATA_WIDTH;

			logic [NODES/2-1:0]       par_valid;
			logic [NODES/2*DW-1:0]    par_data;
			logic [dist_pkg::NUM_PORTS-1:0] par_cmd;
			logic [NODES-1:0]         valid_q;
			logic [NODES*DW-1:0]      data_q;
			logic [dist_pkg::NUM_PORTS-1:0] cmd_q; // node n holds the segment it will split

			if (lvl == 0)
			begin : g_root
				assign par_valid = i_valid;
				assign par_data = i_data;
				assign par_cmd = i_cmd;
			end
			else
			begin : g_inner
				assign par_valid = g_level[lvl-1].valid_q;
				assign par_data = g_level[lvl-1].data_q;
				assign par_cmd = g_level[lvl-1].cmd_q;
			end

			always_ff @(posedge CLK)
			begin
				if (i_rst)
					valid_q <= '0;
				else if (i_en)
					for (int n = 0; n < NODES; n++)
						valid_q[n] <= par_valid[n/2];
			end

			// each child copies its parent, command halves stay in place
			always_ff @(posedge CLK)
			begin
				if (i_en)
				begin
					for (int n = 0; n < NODES; n++)
						data_q[n*DW +: DW] <= par_data[(n/2)*DW +: DW];
					cmd_q <= par_cmd;
				end
			end
		end
	endgenerate

	assign o_valid = g_level[dist_pkg::TREE_DEPTH-1].valid_q;
	assign o_data = g_level[dist_pkg::TREE_DEPTH-1].data_q;
	assign o_cmd = g_level[dist_pkg::TREE_DEPTH-1].cmd_q; // one select bit per leaf

endmodule

// ==== design/crossbar/mux_tree.sv ====
`timescale 1ns/1ps

module mux_tree
(
	input  logic                                          CLK,
	input  logic                                          i_rst,
	input  logic                                          i_en,
	input  logic [dist_pkg::NUM_PORTS-1:0]                i_valid,
	input  logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] i_data,
	input  logic [dist_pkg::NUM_PORTS-1:0]                i_sel,
	output logic                                          o_valid,
	output logic [dist_pkg::DATA_WIDTH-1:0]               o_data
);

	genvar lvl;

	// each level halves the candidates, 8 -> 4 -> 2 -> 1
	generate
		for (lvl = 0; lvl < dist_pkg::TREE_DEPTH; lvl++)
		begin : g_level
			localparam int NODES = dist_pkg::NUM_PORTS >> (lvl + 1);
			localparam int DW = dist_pkg::DATA_WIDTH;

			logic [2*NODES-1:0]    hit;      // child is valid and selected
			logic [2*NODES*DW-1:0] kid_data;
			logic [NODES-1:0]      valid_q;
			logic [NODES*DW-1:0]   data_q;

			if (lvl == 0)
			begin : g_leaf
				assign hit = i_valid & i_sel;
				assign kid_data = i_data;
			end
			else
			begin : g_node
				// upper levels only ever carry selected data
				assign hit = g_level[lvl-1].valid_q;
				assign kid_data = g_level[lvl-1].data_q;
			end

			always_ff @(posedge CLK)
			begin
				if (i_rst)
					valid_q <= '0;
				else if (i_en)
					for (int n = 0; n < NODES; n++)
						valid_q[n] <= hit[2*n] | hit[2*n+1];
			end

			// at most one child hits per lane, left checked first
			always_ff @(posedge CLK)
			begin
				if (i_en)
				begin
					for (int n = 0; n < NODES; n++)
					begin
						if (hit[2*n])
							data_q[n*DW +: DW] <= kid_data[(2*n)*DW +: DW];
						else
							data_q[n*DW +: DW] <= kid_data[(2*n+1)*DW +: DW];
					end
				end
			end
		end
	endgenerate

	assign o_valid = g_level[dist_pkg::TREE_DEPTH-1].valid_q[0];
	assign o_data = g_level[dist_pkg::TREE_DEPTH-1].data_q;

endmodule

// ==== design/crossbar/crossbar_one_hot.sv ====
`timescale 1ns/1ps

module crossbar_one_hot
(
	input  logic                                          CLK,
	input  logic                                          i_rst,
	input  logic                                          i_en,
	input  logic [dist_pkg::NUM_PORTS-1:0]                i_valid,
	input  logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] i_data_bus,
	input  logic [dist_pkg::CMD_WIDTH-1:0]                i_cmd,
	output logic [dist_pkg::NUM_PORTS-1:0]                o_valid,
	output logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] o_data_bus
);

	localparam int N = dist_pkg::NUM_PORTS;
	localparam int DW = dist_pkg::DATA_WIDTH;

	// fan_* indexed [tree i][leaf j], mux_* indexed [lane j][input i]
	logic [N*N-1:0]    fan_valid;
	logic [N*N-1:0]    fan_sel;
	logic [N*N*DW-1:0] fan_data;
	logic [N*N-1:0]    mux_valid;
	logic [N*N-1:0]    mux_sel;
	logic [N*N*DW-1:0] mux_data;

	genvar i, j;

	generate
		for (i = 0; i < N; i++)
		begin : g_fan
			fanout_tree u_fan
			(
				.CLK     (CLK),
				.i_rst   (i_rst),
				.i_en    (i_en),
				.i_valid (i_valid[i]),
				.i_data  (i_data_bus[i*DW +: DW]),
				.i_cmd   (i_cmd[i*N +: N]),  // lanes this input feeds
				.o_valid (fan_valid[i*N +: N]),
				.o_data  (fan_data[i*N*DW +: N*DW]),
				.o_cmd   (fan_sel[i*N +: N])
			);
		end

		// leaf j of tree i becomes input i of lane j
		for (i = 0; i < N; i++)
		begin : g_row
			for (j = 0; j < N; j++)
			begin : g_col
				assign mux_valid[j*N+i] = fan_valid[i*N+j];
				assign mux_sel[j*N+i] = fan_sel[i*N+j];
				assign mux_data[(j*N+i)*DW +: DW] = fan_data[(i*N+j)*DW +: DW];
			end
		end

		for (j = 0; j < N; j++)
		begin : g_mux
			mux_tree u_mux
			(
				.CLK     (CLK),
				.i_rst   (i_rst),
				.i_en    (i_en),
				.i_valid (mux_valid[j*N +: N]),
				.i_data  (mux_data[j*N*DW +: N*DW]),
				.i_sel   (mux_sel[j*N +: N]),
				.o_valid (o_valid[j]),
				.o_data  (o_data_bus[j*DW +: DW])
			);
		end
	endgenerate

endmodule

// ==== design/round_counter.sv ====
`timescale 1ns/1ps

module round_counter
(
	input  logic                              CLK,
	input  logic                              i_rst,
	input  logic                              i_clear,
	input  logic                              i_step,
	output logic [dist_pkg::COUNT_BITS-1:0]   o_count
);

	// round index during issue, drain timer afterwards
	always_ff @(posedge CLK)
	begin
		if (i_rst)
			o_count <= '0;
		else if (i_clear)
			o_count <= '0;
		else if (i_step)
			o_count <= o_count + 1'b1;
	end

endmodule

// ==== design/dist_sequencer.sv ====
`timescale 1ns/1ps

module dist_sequencer
(
	input  logic                              CLK,
	input  logic                              i_rst,
	input  logic                              i_start,
	input  logic                              i_hold,
	input  logic [dist_pkg::ROUND_BITS-1:0]   i_num_rounds, // rounds minus one
	input  logic [dist_pkg::COUNT_BITS-1:0]   i_count,
	output logic                              o_clear,
	output logic                              o_step,
	output logic                              o_issue,
	output logic                              o_xbar_en,
	output logic                              o_busy,
	output logic                              o_done
);

	dist_pkg::seq_state_e state_q;
	dist_pkg::seq_state_e state_d;

	always_ff @(posedge CLK)
	begin
		if (i_rst)
			state_q <= dist_pkg::ST_IDLE;
		else
			state_q <= state_d;
	end

	// nothing moves while held
	always_comb
	begin
		state_d = state_q;
		o_clear = 1'b0;
		o_step = 1'b0;
		if (!i_hold)
		begin
			unique case (state_q)
				dist_pkg::ST_IDLE:
				begin
					if (i_start)
					begin
						o_clear = 1'b1; // round 0 first
						state_d = dist_pkg::ST_ISSUE;
					end
				end
				dist_pkg::ST_ISSUE:
				begin
					if (int'(i_count) == int'(i_num_rounds))
					begin
						o_clear = 1'b1; // counter now times the drain
						state_d = dist_pkg::ST_DRAIN;
					end
					else
						o_step = 1'b1;
				end
				dist_pkg::ST_DRAIN:
				begin
					if (int'(i_count) == dist_pkg::XBAR_LATENCY - 1)
						state_d = dist_pkg::ST_DONE;
					else
						o_step = 1'b1;
				end
				dist_pkg::ST_DONE:
					state_d = dist_pkg::ST_IDLE;
				default:
					state_d = dist_pkg::ST_IDLE;
			endcase
		end
	end

	assign o_xbar_en = !i_hold;
	assign o_issue = (state_q == dist_pkg::ST_ISSUE) && !i_hold;
	assign o_busy = (state_q == dist_pkg::ST_ISSUE) || (state_q == dist_pkg::ST_DRAIN);
	assign o_done = (state_q == dist_pkg::ST_DONE) && !i_hold; // single enabled cycle

endmodule

// ==== design/operand_bank.sv ====
`timescale 1ns/1ps

module operand_bank
(
	input  logic                                          CLK,
	input  logic                                          i_rst,
	input  logic                                          i_busy,
	input  logic                                          i_wr_en,
	input  logic [2:0]                                    i_wr_addr,
	input  logic [dist_pkg::DATA_WIDTH-1:0]               i_wr_data,
	input  logic                                          i_cmd_wr,
	input  logic [dist_pkg::ROUND_BITS-1:0]               i_cmd_addr,
	input  logic [dist_pkg::CMD_WIDTH-1:0]                i_cmd_data,
	input  logic [dist_pkg::ROUND_BITS-1:0]               i_round,
	output logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] o_operands,
	output logic [dist_pkg::CMD_WIDTH-1:0]                o_cmd
);

	localparam int DW = dist_pkg::DATA_WIDTH;

	logic [DW-1:0]                  operand_q [dist_pkg::NUM_PORTS];
	logic [dist_pkg::CMD_WIDTH-1:0] cmd_q [dist_pkg::MAX_ROUNDS];

	// host writes land only between runs
	always_ff @(posedge CLK)
	begin
		if (i_wr_en && !i_busy)
			operand_q[i_wr_addr] <= i_wr_data;
	end

	// an unwritten round routes nothing
	always_ff @(posedge CLK)
	begin
		if (i_rst)
		begin
			for (int r = 0; r < dist_pkg::MAX_ROUNDS; r++)
				cmd_q[r] <= '0;
		end
		else if (i_cmd_wr && !i_busy)
			cmd_q[i_cmd_addr] <= i_cmd_data;
	end

	always_comb
	begin
		for (int p = 0; p < dist_pkg::NUM_PORTS; p++)
			o_operands[p*DW +: DW] = operand_q[p];
	end

	assign o_cmd = cmd_q[i_round]; // follows the round index directly

endmodule

// ==== design/dist_top.sv ====
`timescale 1ns/1ps

module dist_top
(
	input  logic                                          CLK,
	input  logic                                          i_rst,
	input  logic                                          i_wr_en,
	input  logic [2:0]                                    i_wr_addr,
	input  logic [dist_pkg::DATA_WIDTH-1:0]               i_wr_data,
	input  logic                                          i_cmd_wr,
	input  logic [dist_pkg::ROUND_BITS-1:0]               i_cmd_addr,
	input  logic [dist_pkg::CMD_WIDTH-1:0]                i_cmd_data,
	input  logic                                          i_start,
	input  logic [dist_pkg::ROUND_BITS-1:0]               i_num_rounds,
	input  logic                                          i_hold,
	output logic [dist_pkg::NUM_PORTS-1:0]                o_valid,
	output logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] o_data_bus,
	output logic                                          o_busy,
	output logic                                          o_done
);

	logic                                          clear;
	logic                                          step;
	logic                                          issue;
	logic                                          xbar_en;
	logic [dist_pkg::COUNT_BITS-1:0]               count;
	logic [dist_pkg::NUM_PORTS*dist_pkg::DATA_WIDTH-1:0] operands;
	logic [dist_pkg::CMD_WIDTH-1:0]                round_cmd;

	operand_bank u_bank
	(
		.CLK        (CLK),
		.i_rst      (i_rst),
		.i_busy     (o_busy),
		.i_wr_en    (i_wr_en),
		.i_wr_addr  (i_wr_addr),
		.i_wr_data  (i_wr_data),
		.i_cmd_wr   (i_cmd_wr),
		.i_cmd_addr (i_cmd_addr),
		.i_cmd_data (i_cmd_data),
		.i_round    (count[dist_pkg::ROUND_BITS-1:0]),
		.o_operands (operands),
		.o_cmd      (round_cmd)
	);

	dist_sequencer u_seq
	(
		.CLK          (CLK),
		.i_rst        (i_rst),
		.i_start      (i_start),
		.i_hold       (i_hold),
		.i_num_rounds (i_num_rounds),
		.i_count      (count),
		.o_clear      (clear),
		.o_step       (step),
		.o_issue      (issue),
		.o_xbar_en    (xbar_en),
		.o_busy       (o_busy),
		.o_done       (o_done)
	);

	round_counter u_count
	(
		.CLK     (CLK),
		.i_rst   (i_rst),
		.i_clear (clear),
		.i_step  (step),
		.o_count (count)
	);

	// every operand enters with the same issue strobe
	crossbar_one_hot u_xbar
	(
		.CLK        (CLK),
		.i_rst      (i_rst),
		.i_en       (xbar_en),
		.i_valid    ({dist_pkg::NUM_PORTS{issue}}),
		.i_data_bus (operands),
		.i_cmd      (round_cmd),
		.o_valid    (o_valid),
		.o_data_bus (o_data_bus)
	);

endmodule

// ==== verification/dist_tb.sv ====
`timescale 1ns/1ps

module dist_tb;

	localparam int N = dist_pkg::NUM_PORTS;
	localparam int DW = dist_pkg::DATA_WIDTH;
	localparam int CW = dist_pkg::CMD_WIDTH;
	localparam int RB = dist_pkg::ROUND_BITS;
	localparam int BW = N * DW;
	localparam int LAT = dist_pkg::XBAR_LATENCY;
	localparam int TIMEOUT_CYCLES = 3000; // full sequence runs a few hundred cycles

	logic          CLK = 1'b0;
	logic          i_rst;
	logic          i_wr_en;
	logic [2:0]    i_wr_addr;
	logic [DW-1:0] i_wr_data;
	logic          i_cmd_wr;
	logic [RB-1:0] i_cmd_addr;
	logic [CW-1:0] i_cmd_data;
	logic          i_start;
	logic [RB-1:0] i_num_rounds;
	logic          i_hold;
	logic [N-1:0]  o_valid;
	logic [BW-1:0] o_data_bus;
	logic          o_busy;
	logic          o_done;

	logic [31:0]   rng_state;
	logic [DW-1:0] model_ops [N];
	logic [CW-1:0] model_cmd [dist_pkg::MAX_ROUNDS];
	logic [N-1:0]  q_valid [$]; // started rounds not yet in the crossbar
	logic [BW-1:0] q_data [$];
	logic [N-1:0]  pipe_valid [LAT];
	logic [BW-1:0] pipe_data [LAT];
	logic          exp_busy;
	logic          done_pend;
	int            drain_left;
	bit            checking;
	int            cycles;

	dist_top UUT (.*);

	always #20 CLK = ~CLK;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// shuffled lane per input, one bit per input row
	function automatic logic [CW-1:0] random_perm_cmd();
		int lane [N];
		int k;
		int t;
		logic [CW-1:0] cmd;
		for (int i = 0; i < N; i++)
			lane[i] = i;
		for (int i = N - 1; i > 0; i--)
		begin
			k = int'(next_rand() % (i + 1));
			t = lane[i];
			lane[i] = lane[k];
			lane[k] = t;
		end
		cmd = '0;
		for (int i = 0; i < N; i++)
			cmd[i*N+lane[i]] = 1'b1;
		return cmd;
	endfunction

	task automatic report_mismatch(input string name, input logic [BW-1:0] expected,
		input logic [BW-1:0] actual);
		$display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "wrong value on %s", name);
	endtask

	task automatic step();
		@(posedge CLK);
		#2;
	endtask

	task automatic host_write(input bit is_cmd, input int addr, input logic [CW-1:0] value);
		step();
		i_wr_en = !is_cmd;
		i_wr_addr = 3'(addr);
		i_wr_data = value[DW-1:0];
		i_cmd_wr = is_cmd;
		i_cmd_addr = RB'(addr);
		i_cmd_data = value;
		step();
		i_wr_en = 1'b0;
		i_cmd_wr = 1'b0;
	endtask

	task automatic load_operands();
		for (int p = 0; p < N; p++)
			host_write(1'b0, p, CW'(next_rand()));
	endtask

	task automatic load_commands();
		for (int r = 0; r < dist_pkg::MAX_ROUNDS; r++)
			host_write(1'b1, r, random_perm_cmd());
	endtask

	// start pulse, then wait for done with optional holds and stray host writes
	task automatic run_rounds(input int rounds, input bit with_hold, input bit with_junk);
		logic [31:0] r;
		bit seen;
		seen = 1'b0;
		step();
		i_start = 1'b1;
		i_num_rounds = RB'(rounds - 1);
		i_hold = 1'b0;
		step();
		i_start = 1'b0;
		while (!seen)
		begin
			r = next_rand();
			i_hold = with_hold && (next_rand() % 3 == 0);
			i_wr_en = with_junk && exp_busy; // only while the run is busy
			i_wr_addr = r[2:0];
			i_wr_data = next_rand();
			i_cmd_wr = with_junk && exp_busy;
			i_cmd_addr = r[4:3];
			i_cmd_data = {next_rand(), next_rand()};
			@(negedge CLK);
			seen = o_done;
			step();
		end
		i_hold = 1'b0;
		i_wr_en = 1'b0;
		i_cmd_wr = 1'b0;
	endtask

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("TESTS FAILED");
			$fatal(1, "timeout, sequence still running after %0d cycles", cycles);
		end
	end

	// expected lane values, shifted only on enabled cycles
	always @(posedge CLK)
	begin
		logic [N-1:0] v;
		logic [BW-1:0] d;
		if (i_rst)
		begin
			for (int s = 0; s < LAT; s++)
			begin
				pipe_valid[s] = '0;
				pipe_data[s] = '0;
			end
			for (int r = 0; r < dist_pkg::MAX_ROUNDS; r++)
				model_cmd[r] = '0;
			q_valid.delete();
			q_data.delete();
			exp_busy = 1'b0;
			done_pend = 1'b0;
			drain_left = 0;
		end
		else
		begin
			if (i_wr_en && !exp_busy)
				model_ops[i_wr_addr] = i_wr_data;
			if (i_cmd_wr && !exp_busy)
				model_cmd[i_cmd_addr] = i_cmd_data;
			if (!i_hold)
			begin
				done_pend = 1'b0;
				if (drain_left > 0)
				begin
					drain_left--;
					if (drain_left == 0)
					begin
						done_pend = 1'b1;
						exp_busy = 1'b0;
					end
				end
				for (int s = LAT - 1; s > 0; s--)
				begin
					pipe_valid[s] = pipe_valid[s-1];
					pipe_data[s] = pipe_data[s-1];
				end
				pipe_valid[0] = '0;
				if (q_valid.size() > 0)
				begin
					pipe_valid[0] = q_valid.pop_front();
					pipe_data[0] = q_data.pop_front();
					if (q_valid.size() == 0)
						drain_left = LAT; // done after the last round clears the crossbar
				end
				if (i_start)
				begin
					for (int r = 0; r <= int'(i_num_rounds); r++)
					begin
						v = '0;
						d = '0;
						// lane j carries operand i when bit i*N+j is set
						for (int i = 0; i < N; i++)
							for (int j = 0; j < N; j++)
								if (model_cmd[r][i*N+j])
								begin
									v[j] = 1'b1;
									d[j*DW +: DW] = model_ops[i];
								end
						q_valid.push_back(v);
						q_data.push_back(d);
					end
					exp_busy = 1'b1;
				end
			end
		end
	end

	// outputs settle at posedge, compared mid cycle
	always @(negedge CLK)
	begin
		if (checking)
		begin
			assert (o_busy === exp_busy)
			else report_mismatch("o_busy", BW'(exp_busy), BW'(o_busy));
			assert (o_done === (done_pend && !i_hold))
			else report_mismatch("o_done", BW'(done_pend && !i_hold), BW'(o_done));
			assert (o_valid === pipe_valid[LAT-1])
			else report_mismatch("o_valid", BW'(pipe_valid[LAT-1]), BW'(o_valid));
			for (int j = 0; j < N; j++)
			begin
				if (pipe_valid[LAT-1][j])
				begin
					assert (o_data_bus[j*DW +: DW] === pipe_data[LAT-1][j*DW +: DW])
					else report_mismatch($sformatf("o_data_bus lane %0d", j),
						BW'(pipe_data[LAT-1][j*DW +: DW]), BW'(o_data_bus[j*DW +: DW]));
				end
			end
		end
	end

	initial
	begin
		logic [CW-1:0] cmd;
		int a;
		rng_state = 32'h0d83_fb60;
		i_rst = 1'b1;
		i_wr_en = 1'b0;
		i_wr_addr = '0;
		i_wr_data = '0;
		i_cmd_wr = 1'b0;
		i_cmd_addr = '0;
		i_cmd_data = '0;
		i_start = 1'b0;
		i_num_rounds = '0;
		i_hold = 1'b0;
		checking = 1'b0;
		cycles = 0;
		repeat (2) @(posedge CLK);
		#2;
		i_rst = 1'b0;
		checking = 1'b1;
		repeat (6) step(); // quiet until the first start

		load_operands();
		host_write(1'b1, 0, random_perm_cmd());
		run_rounds(1, 1'b0, 1'b0);

		// one input copied to lanes 0, 2 and 5, its neighbour to lane 7
		a = int'(next_rand() % N);
		cmd = '0;
		cmd[a*N+0] = 1'b1;
		cmd[a*N+2] = 1'b1;
		cmd[a*N+5] = 1'b1;
		cmd[((a+1)%N)*N+7] = 1'b1;
		host_write(1'b1, 0, cmd);
		run_rounds(1, 1'b0, 1'b0);

		load_operands();
		load_commands();
		run_rounds(4, 1'b0, 1'b0);

		repeat (6)
		begin
			load_commands();
			run_rounds(4, 1'b1, 1'b0);
		end

		// stray writes while busy, later runs still see the earlier table
		load_operands();
		load_commands();
		run_rounds(4, 1'b1, 1'b1);
		run_rounds(3, 1'b0, 1'b1);
		run_rounds(4, 1'b0, 1'b0);
		repeat (LAT + 4) step();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== dist_top.f ====
common/dist_pkg.sv
design/crossbar/fanout_tree.sv
design/crossbar/mux_tree.sv
design/crossbar/crossbar_one_hot.sv
design/round_counter.sv
design/dist_sequencer.sv
design/operand_bank.sv
design/dist_top.sv
verification/dist_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := dist_tb
FILELIST  := dist_top.f
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
